// ==== Bender.yml ====
package:
  name: singleBusCpu

sources:
  - files:
      - rtl/cpuIsaPkg.sv
      - rtl/cpuCtrlPkg.sv
      - rtl/registerFile.sv
      - rtl/aluUnit.sv
      - rtl/microSequencer.sv
      - rtl/busDatapath.sv
      - rtl/singleBusCpu.sv
  - target: test
    files:
      - sim/singleBusCpuTb.sv

// ==== compile.f ====
rtl/cpuIsaPkg.sv
rtl/cpuCtrlPkg.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/microSequencer.sv
rtl/busDatapath.sv
rtl/singleBusCpu.sv
sim/singleBusCpuTb.sv

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  cpuCtrlPkg::aluOp_e                op,
    input  logic [cpuIsaPkg::DataWidth-1:0]   yValue,
    input  logic [cpuIsaPkg::DataWidth-1:0]   busValue,
    output logic [cpuIsaPkg::DataWidth-1:0]   zValue
);

    localparam int Width      = cpuIsaPkg::DataWidth;
    localparam int ShiftWidth = $clog2(Width);

    logic [ShiftWidth-1:0] shiftAmount;

    // Only the low bits of the bus count as a shift distance
    assign shiftAmount = busValue[ShiftWidth-1:0];

    always_comb begin
        case (op)
            cpuCtrlPkg::AluAdd: begin
                zValue = yValue + busValue;
            end
            cpuCtrlPkg::AluSub: begin
                zValue = yValue - busValue;  // Y minus bus
            end
            cpuCtrlPkg::AluAnd: begin
                zValue = yValue & busValue;
            end
            cpuCtrlPkg::AluOr: begin
                zValue = yValue | busValue;
            end
            cpuCtrlPkg::AluShl: begin
                zValue = yValue << shiftAmount;
            end
            cpuCtrlPkg::AluShr: begin
                zValue = yValue >> shiftAmount;  // Logical, zero fill
            end
            cpuCtrlPkg::AluInc: begin
                zValue = busValue + Width'(1);   // PC + 1 during fetch
            end
            default: begin
                zValue = '0;
            end
        endcase
    end

endmodule

// ==== rtl/busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath #(
    parameter logic [cpuIsaPkg::DataWidth-1:0] ResetPc = '0
) (
    input  logic                                Clock,
    input  logic                                rst,
    input  logic                                pcOut,
    input  logic                                zLowOut,
    input  logic                                mdrOut,
    input  logic                                regOut,
    input  logic                                cOut,
    input  logic                                pcIn,
    input  logic                                marIn,
    input  logic                                mdrIn,
    input  logic                                irIn,
    input  logic                                yIn,
    input  logic                                zIn,
    input  logic                                regIn,
    input  logic                                incPc,
    input  logic                                memRead,
    input  logic                                selA,
    input  logic                                selB,
    input  logic                                selC,
    input  cpuCtrlPkg::aluOp_e                  aluOp,
    input  logic [cpuIsaPkg::DataWidth-1:0]     memData,
    output logic [cpuIsaPkg::DataWidth-1:0]     memAddr,
    output cpuIsaPkg::instr_u                   irWord,
    output logic [cpuIsaPkg::DataWidth-1:0]     result
);

    localparam int Width    = cpuIsaPkg::DataWidth;
    localparam int ImmWidth = cpuIsaPkg::ImmWidth;

    logic [Width-1:0]   pc;
    logic [Width-1:0]   mar;
    logic [Width-1:0]   mdr;
    logic [Width-1:0]   y;
    logic [Width-1:0]   z;
    cpuIsaPkg::instr_u  ir;

    logic [Width-1:0]   busValue;
    logic [Width-1:0]   regBusOut;  // Already gated by regOut
    logic [Width-1:0]   immExt;
    logic [Width-1:0]   aluResult;
    cpuCtrlPkg::aluOp_e aluSel;

    assign immExt = {{(Width - ImmWidth){ir.iFormat.imm[ImmWidth-1]}}, ir.iFormat.imm};

    // One-hot AND-OR bus, reads zero when nobody drives
    assign busValue = ({Width{pcOut}}   & pc)
                    | ({Width{zLowOut}} & z)
                    | ({Width{mdrOut}}  & mdr)
                    | ({Width{cOut}}    & immExt)
                    | regBusOut;

    // Fetch increment overrides the decoded operation
    always_comb begin
        if (incPc) begin
            aluSel = cpuCtrlPkg::AluInc;
        end else begin
            aluSel = aluOp;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc  <= ResetPc;
            mar <= '0;
            z   <= '0;
        end else begin
            if (pcIn)  pc  <= busValue;
            if (marIn) mar <= busValue;
            if (zIn)   z   <= aluResult;
        end
    end

    always_ff @(posedge Clock) begin
        if (memRead && mdrIn) mdr <= memData;  // Memory answers in the same cycle
        if (irIn)             ir  <= busValue;
        if (yIn)              y   <= busValue;
    end

    registerFile registerFile_i (
        .Clock  (Clock),
        .rst    (rst),
        .regIn  (regIn),
        .regOut (regOut),
        .selA   (selA),
        .selB   (selB),
        .selC   (selC),
        .irWord (ir),
        .busIn  (busValue),
        .busOut (regBusOut)
    );

    aluUnit aluUnit_i (
        .op       (aluSel),
        .yValue   (y),
        .busValue (busValue),
        .zValue   (aluResult)
    );

    assign memAddr = mar;
    assign irWord  = ir;
    assign result  = z;

endmodule

// ==== rtl/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    localparam int StepWidth  = 3;
    localparam int AluOpWidth = 3;

    // One instruction walks T0..T5 then goes back to Idle
    typedef enum logic [StepWidth-1:0] {
        Idle = 3'd0,
        T0   = 3'd1,  // PC to MAR, Z gets PC + 1
        T1   = 3'd2,  // Z to PC, memory to MDR
        T2   = 3'd3,  // MDR to IR
        T3   = 3'd4,  // Rb to Y
        T4   = 3'd5,  // Second operand through the ALU into Z
        T5   = 3'd6   // Z to Ra
    } step_e;

    typedef enum logic [AluOpWidth-1:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluShl = 3'd4,
        AluShr = 3'd5,
        AluInc = 3'd6   // Bus + 1, Y ignored
    } aluOp_e;

endpackage

// ==== rtl/cpuIsaPkg.sv ====
package cpuIsaPkg;

    localparam int DataWidth     = 32;
    localparam int RegIndexWidth = 4;  // Sixteen registers
    localparam int OpcodeWidth   = 5;

    // Field widths left over once opcode and register fields are placed
    localparam int ImmWidth   = DataWidth - OpcodeWidth - 2 * RegIndexWidth;
    localparam int SpareWidth = DataWidth - OpcodeWidth - 3 * RegIndexWidth;

    typedef enum logic [OpcodeWidth-1:0] {
        OpAdd  = 5'd0,
        OpSub  = 5'd1,
        OpAnd  = 5'd2,
        OpOr   = 5'd3,
        OpShl  = 5'd4,
        OpShr  = 5'd5,
        OpAddi = 5'd8,
        OpAndi = 5'd9,
        OpOri  = 5'd10
    } opcode_e;

    // Same word seen as register-register or register-immediate
    typedef union packed {
        struct packed {
            opcode_e                  opcode;  // Bits 31..27
            logic [RegIndexWidth-1:0] ra;      // Destination
            logic [RegIndexWidth-1:0] rb;      // First source
            logic [RegIndexWidth-1:0] rc;      // Second source
            logic [SpareWidth-1:0]    spare;
        } rFormat;
        struct packed {
            opcode_e                  opcode;
            logic [RegIndexWidth-1:0] ra;
            logic [RegIndexWidth-1:0] rb;
            logic signed [ImmWidth-1:0] imm;   // Sign-extended on the bus
        } iFormat;
    } instr_u;

    // Immediate group takes its second operand from the IR
    function automatic logic isImmOp(opcode_e op);
        return op inside {OpAddi, OpAndi, OpOri};
    endfunction

endpackage

// ==== rtl/microSequencer.sv ====
`timescale 1ns/1ps

module microSequencer (
    input  logic                Clock,
    input  logic                rst,
    input  logic                start,
    input  cpuIsaPkg::instr_u   irWord,
    output logic                pcOut,
    output logic                zLowOut,
    output logic                mdrOut,
    output logic                regOut,
    output logic                cOut,
    output logic                pcIn,
    output logic                marIn,
    output logic                mdrIn,
    output logic                irIn,
    output logic                yIn,
    output logic                zIn,
    output logic                regIn,
    output logic                incPc,
    output logic                memRead,
    output logic                selA,
    output logic                selB,
    output logic                selC,
    output logic                done,
    output cpuCtrlPkg::aluOp_e  aluOp
);

    cpuCtrlPkg::step_e step;
    cpuCtrlPkg::step_e stepNext;
    logic              immOp;

    // Immediate forms reuse the register ALU operations
    function automatic cpuCtrlPkg::aluOp_e opToAlu(cpuIsaPkg::opcode_e op);
        case (op)
            cpuIsaPkg::OpAdd, cpuIsaPkg::OpAddi: return cpuCtrlPkg::AluAdd;
            cpuIsaPkg::OpSub:                    return cpuCtrlPkg::AluSub;
            cpuIsaPkg::OpAnd, cpuIsaPkg::OpAndi: return cpuCtrlPkg::AluAnd;
            cpuIsaPkg::OpOr, cpuIsaPkg::OpOri:   return cpuCtrlPkg::AluOr;
            cpuIsaPkg::OpShl:                    return cpuCtrlPkg::AluShl;
            cpuIsaPkg::OpShr:                    return cpuCtrlPkg::AluShr;
            default:                             return cpuCtrlPkg::AluAdd;
        endcase
    endfunction

    always_ff @(posedge Clock) begin
        if (rst) begin
            step <= cpuCtrlPkg::Idle;
        end else begin
            step <= stepNext;
        end
    end

    // Start only counts while Idle
    always_comb begin
        case (step)
            cpuCtrlPkg::Idle: stepNext = start ? cpuCtrlPkg::T0 : cpuCtrlPkg::Idle;
            cpuCtrlPkg::T0:   stepNext = cpuCtrlPkg::T1;
            cpuCtrlPkg::T1:   stepNext = cpuCtrlPkg::T2;
            cpuCtrlPkg::T2:   stepNext = cpuCtrlPkg::T3;
            cpuCtrlPkg::T3:   stepNext = cpuCtrlPkg::T4;
            cpuCtrlPkg::T4:   stepNext = cpuCtrlPkg::T5;
            default:          stepNext = cpuCtrlPkg::Idle;  // T5 wraps
        endcase
    end

    assign immOp = cpuIsaPkg::isImmOp(irWord.iFormat.opcode);

    // Strobes follow the step register directly
    always_comb begin
        pcOut   = 1'b0;
        zLowOut = 1'b0;
        mdrOut  = 1'b0;
        regOut  = 1'b0;
        cOut    = 1'b0;
        pcIn    = 1'b0;
        marIn   = 1'b0;
        mdrIn   = 1'b0;
        irIn    = 1'b0;
        yIn     = 1'b0;
        zIn     = 1'b0;
        regIn   = 1'b0;
        incPc   = 1'b0;
        memRead = 1'b0;
        selA    = 1'b0;
        selB    = 1'b0;
        selC    = 1'b0;
        done    = 1'b0;
        aluOp   = cpuCtrlPkg::AluAdd;
        case (step)
            cpuCtrlPkg::T0: begin
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;  // Datapath forces AluInc
                zIn   = 1'b1;
            end
            cpuCtrlPkg::T1: begin
                zLowOut = 1'b1;
                pcIn    = 1'b1;
                memRead = 1'b1;
                mdrIn   = 1'b1;
            end
            cpuCtrlPkg::T2: begin
                mdrOut = 1'b1;
                irIn   = 1'b1;
            end
            cpuCtrlPkg::T3: begin
                selB   = 1'b1;
                regOut = 1'b1;
                yIn    = 1'b1;
            end
            cpuCtrlPkg::T4: begin
                if (immOp) begin
                    cOut = 1'b1;
                end else begin
                    selC   = 1'b1;
                    regOut = 1'b1;
                end
                aluOp = opToAlu(irWord.iFormat.opcode);
                zIn   = 1'b1;
            end
            cpuCtrlPkg::T5: begin
                zLowOut = 1'b1;
                selA    = 1'b1;
                regIn   = 1'b1;
                done    = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic                              Clock,
    input  logic                              rst,
    input  logic                              regIn,
    input  logic                              regOut,
    input  logic                              selA,
    input  logic                              selB,
    input  logic                              selC,
    input  cpuIsaPkg::instr_u                 irWord,
    input  logic [cpuIsaPkg::DataWidth-1:0]   busIn,
    output logic [cpuIsaPkg::DataWidth-1:0]   busOut
);

    localparam int Width      = cpuIsaPkg::DataWidth;
    localparam int IndexWidth = cpuIsaPkg::RegIndexWidth;
    localparam int NumRegs    = 1 << IndexWidth;

    // R0 has no storage
    logic [Width-1:0]      regs [1:NumRegs-1];
    logic [IndexWidth-1:0] regIndex;
    logic [Width-1:0]      readValue;

    // Select and encode, at most one select is high per step
    always_comb begin
        if (selA) begin
            regIndex = irWord.rFormat.ra;
        end else if (selB) begin
            regIndex = irWord.rFormat.rb;
        end else if (selC) begin
            regIndex = irWord.rFormat.rc;
        end else begin
            regIndex = '0;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn && regIndex != '0) begin
            regs[regIndex] <= busIn;  // Writes to R0 are dropped
        end
    end

    always_comb begin
        if (regIndex == '0) begin
            readValue = '0;
        end else begin
            readValue = regs[regIndex];
        end
    end

    assign busOut = regOut ? readValue : '0;

endmodule

// ==== rtl/singleBusCpu.sv ====
`timescale 1ns/1ps

module singleBusCpu #(
    parameter logic [cpuIsaPkg::DataWidth-1:0] ResetPc = '0
) (
    input  logic                              Clock,
    input  logic                              rst,
    input  logic                              start,
    input  logic [cpuIsaPkg::DataWidth-1:0]   memData,
    output logic [cpuIsaPkg::DataWidth-1:0]   memAddr,
    output logic                              memRead,
    output logic                              done,
    output logic [cpuIsaPkg::DataWidth-1:0]   result
);

    logic pcOut, zLowOut, mdrOut, regOut, cOut;        // Bus sources
    logic pcIn, marIn, mdrIn, irIn, yIn, zIn, regIn;   // Register loads
    logic incPc, selA, selB, selC;
    cpuCtrlPkg::aluOp_e aluOp;
    cpuIsaPkg::instr_u  irWord;

    microSequencer microSequencer_i (
        .Clock   (Clock),   .rst     (rst),     .start   (start),
        .irWord  (irWord),
        .pcOut   (pcOut),   .zLowOut (zLowOut), .mdrOut  (mdrOut),
        .regOut  (regOut),  .cOut    (cOut),
        .pcIn    (pcIn),    .marIn   (marIn),   .mdrIn   (mdrIn),
        .irIn    (irIn),    .yIn     (yIn),     .zIn     (zIn),
        .regIn   (regIn),   .incPc   (incPc),   .memRead (memRead),
        .selA    (selA),    .selB    (selB),    .selC    (selC),
        .done    (done),    .aluOp   (aluOp)
    );

    busDatapath #(
        .ResetPc (ResetPc)
    ) busDatapath_i (
        .Clock   (Clock),   .rst     (rst),
        .pcOut   (pcOut),   .zLowOut (zLowOut), .mdrOut  (mdrOut),
        .regOut  (regOut),  .cOut    (cOut),
        .pcIn    (pcIn),    .marIn   (marIn),   .mdrIn   (mdrIn),
        .irIn    (irIn),    .yIn     (yIn),     .zIn     (zIn),
        .regIn   (regIn),   .incPc   (incPc),   .memRead (memRead),
        .selA    (selA),    .selB    (selB),    .selC    (selC),
        .aluOp   (aluOp),   .memData (memData), .memAddr (memAddr),
        .irWord  (irWord),  .result  (result)
    );

endmodule

// ==== sim/singleBusCpuTb.sv ====
`timescale 1ns/1ps

module singleBusCpuTb;

    localparam logic [31:0] ResetPc  = 32'd16;
    localparam int          NumInstr = 16 + 200 + 24 + 4 + 2;
    localparam int          MemWords = 512;
    localparam int          MaxWait  = 20;  // Cycles from start to done before giving up

    logic        Clock;
    logic        rst;
    logic        start;
    logic [31:0] memData;
    logic [31:0] memAddr;
    logic        memRead;
    logic        done;
    logic [31:0] result;

    logic [31:0] mem [0:MemWords-1];
    logic [31:0] modelRegs [0:15];  // Index 0 is never written
    logic [31:0] fetchPc;
    logic [31:0] expected;
    string       testName;
    int          errors;
    int          doneCount;
    int          issued;
    int          testCount;
    int          testErrBase;

    singleBusCpu #(
        .ResetPc (ResetPc)
    ) singleBusCpu_i (
        .Clock   (Clock),
        .rst     (rst),
        .start   (start),
        .memData (memData),
        .memAddr (memAddr),
        .memRead (memRead),
        .done    (done),
        .result  (result)
    );

    assign memData = mem[memAddr[8:0]];  // Memory answers in the same cycle

    always #2 Clock = ~Clock;

    function automatic logic [31:0] rWord(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
                                          logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] iWord(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
                                          logic [18:0] imm);
        return {op, ra, rb, imm};
    endfunction

    // ISA rules applied to the model registers
    function automatic logic [31:0] refExecute(logic [31:0] word);
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] imm;
        logic [31:0] value;
        op  = word[31:27];
        ra  = word[26:23];
        b   = modelRegs[word[22:19]];
        c   = modelRegs[word[18:15]];
        imm = {{13{word[18]}}, word[18:0]};  // Sign extension of the 19-bit field
        case (op)
            cpuIsaPkg::OpAdd:  value = b + c;
            cpuIsaPkg::OpSub:  value = b - c;
            cpuIsaPkg::OpAnd:  value = b & c;
            cpuIsaPkg::OpOr:   value = b | c;
            cpuIsaPkg::OpShl:  value = b << c[4:0];
            cpuIsaPkg::OpShr:  value = b >> c[4:0];
            cpuIsaPkg::OpAddi: value = b + imm;
            cpuIsaPkg::OpAndi: value = b & imm;
            cpuIsaPkg::OpOri:  value = b | imm;
            default:           value = 'x;
        endcase
        if (ra != 4'd0) modelRegs[ra] = value;
        return value;
    endfunction

    // Checks every completed instruction while done is high
    always @(negedge Clock) begin
        if (!rst && done) begin
            expected = refExecute(mem[fetchPc[8:0]]);
            doneCount++;
            if (result !== expected) begin
                $display("MISMATCH %s result: expected %h actual %h", testName, expected, result);
                errors++;
            end
            if (memAddr !== fetchPc) begin
                $display("MISMATCH %s memAddr: expected %h actual %h", testName, fetchPc, memAddr);
                errors++;
            end
        end
    end

    task automatic beginTest(string name);
        testName    = name;
        testErrBase = errors;
        testCount++;
    endtask

    task automatic endTest(int count);
        $display("test %s finished: %0d instructions, %0d errors", testName, count,
                 errors - testErrBase);
    endtask

    // Places the word at the fetch address, pulses start and waits for done
    task automatic issue(logic [31:0] word, bit extraStart);
        int cycles;
        cycles = 0;
        mem[fetchPc[8:0]] = word;
        issued++;
        start = 1'b1;
        @(negedge Clock);
        start = 1'b0;
        while (!done && cycles < MaxWait) begin
            // Fetch reads memory only in T1, the second cycle after start
            if (memRead !== (cycles == 1)) begin
                $display("MISMATCH %s memRead at cycle %0d: expected %b actual %b", testName,
                         cycles + 1, cycles == 1, memRead);
                errors++;
            end
            if (memRead && memAddr !== fetchPc) begin
                $display("MISMATCH %s fetch address: expected %h actual %h", testName, fetchPc,
                         memAddr);
                errors++;
            end
            start = extraStart && (cycles == 2);  // Lands while the instruction is in T2
            @(negedge Clock);
            cycles++;
        end
        start = 1'b0;
        if (!done) begin
            $display("Timeout: no done within %0d cycles for the instruction at %h in %s",
                     MaxWait, fetchPc, testName);
            errors++;
        end else if (cycles + 1 != 6) begin
            $display("MISMATCH %s done latency in cycles: expected 6 actual %0d", testName,
                     cycles + 1);
            errors++;
        end
        @(negedge Clock);
        fetchPc++;
    endtask

    initial begin
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [18:0] imm;
        int          doneBase;
        Clock = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        errors    = 0;
        doneCount = 0;
        issued    = 0;
        testCount = 0;
        fetchPc   = ResetPc;
        testName  = "reset";
        for (int a = 0; a < MemWords; a++) mem[a] = 32'(a) * 32'h9e37_79b9;
        for (int r = 0; r < 16; r++) modelRegs[r] = '0;
        void'($urandom(32'hb6cb_27f5));
        repeat (2) @(negedge Clock);
        rst = 1'b0;

        beginTest("resetIdle");
        repeat (5) begin
            @(negedge Clock);
            if (done !== 1'b0 || memRead !== 1'b0) begin
                $display("done or memRead was not low while idle after reset");
                errors++;
            end
        end
        endTest(0);

        beginTest("addiLoad");  // First fetch must come from address 16
        for (int i = 0; i < 16; i++) begin
            issue(iWord(cpuIsaPkg::OpAddi, 4'(1 + i % 15), 4'd0, 19'($urandom)), 1'b0);
        end
        endTest(16);

        beginTest("rFormatRandom");
        for (int i = 0; i < 200; i++) begin
            op = 5'($urandom % 6);
            ra = 4'($urandom);
            rb = 4'($urandom);
            rc = 4'($urandom);
            if (i % 8 == 0) rb = ra;
            else if (i % 8 == 1) rc = ra;
            issue(rWord(op, ra, rb, rc), 1'b0);
        end
        endTest(200);

        beginTest("immediateRandom");
        for (int i = 0; i < 24; i++) begin
            case (i % 3)
                0:       op = cpuIsaPkg::OpAddi;
                1:       op = cpuIsaPkg::OpAndi;
                default: op = cpuIsaPkg::OpOri;
            endcase
            imm = 19'($urandom);
            if (i % 2 == 0) imm[18] = 1'b1;  // Negative immediate
            issue(iWord(op, 4'($urandom), 4'($urandom), imm), 1'b0);
        end
        endTest(24);

        beginTest("extraStart");
        doneBase = doneCount;
        for (int i = 0; i < 4; i++) begin
            issue(rWord(5'($urandom % 6), 4'($urandom), 4'($urandom), 4'($urandom)), 1'b1);
        end
        repeat (8) @(negedge Clock);
        if (doneCount - doneBase != 4) begin
            $display("Saw %0d done pulses for 4 instructions in %s", doneCount - doneBase,
                     testName);
            errors++;
        end
        endTest(4);

        beginTest("r0Write");
        issue(rWord(cpuIsaPkg::OpAdd, 4'd0, 4'd3, 4'd4), 1'b0);  // Result shows but R0 stays zero
        issue(rWord(cpuIsaPkg::OpAdd, 4'd5, 4'd0, 4'd6), 1'b0);
        endTest(2);

        $display("%0d tests, %0d instructions, %0d done pulses, %0d errors", testCount, issued,
                 doneCount, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ten cycles per instruction plus margin for reset and idle checks
    initial begin
        #(NumInstr * 10 * 4 + 200);
        $display("Watchdog expired after %0d ns before all tests finished",
                 NumInstr * 10 * 4 + 200);
        $display("Simulation failed");
        $finish;
    end

endmodule
